//--- design/assoc_cache.sv
// Two-way associative store.
// Looks the address up in both ways, returns hit and data, and on a fill
// writes the hit way or else the LRU victim. Used ways are marked recent.

`timescale 1ns/1ps
`default_nettype none

module assoc_cache (
  input  logic                 clk,
  input  logic                 resetn,
  input  dcache_pkg::dc_addr_u lookup_addr_i,
  input  logic                 lookup_use_i,
  input  logic                 fill_we_i,
  input  logic [31:0]          fill_data_i,
  output logic                 hit_o,
  output logic [31:0]          hit_data_o
);

  import dcache_pkg::*;

  dc_idx_t     idx;
  dc_tag_t     tag;
  logic        match0;
  logic        match1;
  logic [31:0] data0;
  logic [31:0] data1;
  logic        hit_way;
  logic        victim;
  logic        fill_way;
  logic        touch;

  assign idx = lookup_addr_i.f.idx;
  assign tag = lookup_addr_i.f.tag;

  way_store u_way0 (
    .clk      (clk),
    .resetn   (resetn),
    .rd_idx_i (idx),
    .rd_tag_i (tag),
    .we_i     (fill_we_i && !fill_way),
    .wdata_i  (fill_data_i),
    .match_o  (match0),
    .data_o   (data0)
  );

  way_store u_way1 (
    .clk      (clk),
    .resetn   (resetn),
    .rd_idx_i (idx),
    .rd_tag_i (tag),
    .we_i     (fill_we_i && fill_way),
    .wdata_i  (fill_data_i),
    .match_o  (match1),
    .data_o   (data1)
  );

  assign hit_o      = match0 || match1;
  assign hit_way    = match1;
  assign hit_data_o = match1 ? data1 : data0;

  // a present line is updated in place, otherwise the victim is replaced.
  assign fill_way = hit_o ? hit_way : victim;
  assign touch    = fill_we_i || (lookup_use_i && hit_o);

  replace_lru u_lru (
    .clk         (clk),
    .resetn      (resetn),
    .idx_i       (idx),
    .touch_i     (touch),
    .touch_way_i (fill_way),
    .victim_o    (victim)
  );

  // a fill never creates a duplicate tag in the other way.
  a_single_match: assert property (
    @(posedge clk) disable iff (!resetn) !(match0 && match1)
  );

endmodule

`default_nettype wire

//--- design/dcache_ctrl.sv
// Write-through data cache controller.
// Accepts one CPU request at a time, answers read hits from the store,
// fetches read misses from memory and sends every write through to it,
// merging write hits into the cached word.

`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
  input  logic                 clk,
  input  logic                 resetn,
  // cpu side.
  input  logic [31:0]          cpu_addr_i,
  input  logic [3:0]           cpu_wmask_i,
  input  logic [31:0]          cpu_din_i,
  input  logic                 cpu_valid_i,
  output logic [31:0]          cpu_dout_o,
  output logic                 cpu_ready_o,
  // memory side.
  output logic [31:0]          ram_addr_o,
  output logic [3:0]           ram_wmask_o,
  output logic [31:0]          ram_wdata_o,
  input  logic [31:0]          ram_rdata_i,
  output logic                 ram_valid_o,
  input  logic                 ram_ready_i,
  // associative store.
  output dcache_pkg::dc_addr_u lookup_addr_o,
  output logic                 lookup_use_o,
  output logic                 fill_we_o,
  output logic [31:0]          fill_data_o,
  input  logic                 hit_i,
  input  logic [31:0]          hit_data_i
);

  import dcache_pkg::*;

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_RMISS = 2'd1;
  localparam logic [1:0] ST_RHIT  = 2'd2;
  localparam logic [1:0] ST_WRITE = 2'd3;

  logic [1:0]  state_q;
  logic [1:0]  state_d;
  logic        in_idle;
  logic        accept;
  logic        req_hit_q;
  dc_addr_u    req_addr_q;
  logic [31:0] req_wdata_q;
  logic [3:0]  req_wmask_q;
  logic        req_full;

  // byte-lane merge of new write data into an old word.
  function automatic logic [31:0] merge_bytes(
    input logic [31:0] old_w,
    input logic [31:0] new_w,
    input logic [3:0]  mask
  );
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign in_idle  = (state_q == ST_IDLE);
  assign accept   = in_idle && cpu_valid_i;
  assign req_full = &req_wmask_q;

  // the live address is looked up while idle and the held one afterwards.
  assign lookup_addr_o = in_idle ? cpu_addr_i : req_addr_q.raw;
  assign lookup_use_o  = accept;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (accept) begin
          if (cpu_wmask_i != 4'b0000) begin
            state_d = ST_WRITE;
          end else if (hit_i) begin
            state_d = ST_RHIT;
          end else begin
            state_d = ST_RMISS;
          end
        end
      end
      ST_RHIT: begin
        state_d = ST_IDLE;
      end
      ST_RMISS, ST_WRITE: begin
        if (ram_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state_q   <= ST_IDLE;
      req_hit_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        req_hit_q <= hit_i;
      end
    end
  end

  // request payload.
  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr_q.raw <= cpu_addr_i;
      req_wdata_q    <= cpu_din_i;
      req_wmask_q    <= cpu_wmask_i;
    end
  end

  // the memory request is held up to and including the ram_ready_i cycle.
  assign ram_addr_o  = req_addr_q.raw;
  assign ram_wdata_o = req_wdata_q;
  assign ram_valid_o = (state_q == ST_RMISS) || (state_q == ST_WRITE);
  assign ram_wmask_o = (state_q == ST_WRITE) ? req_wmask_q : 4'b0000;

  always_comb begin
    cpu_ready_o = 1'b0;
    cpu_dout_o  = ram_rdata_i;
    fill_we_o   = 1'b0;
    fill_data_o = ram_rdata_i;
    case (state_q)
      ST_RHIT: begin
        cpu_ready_o = 1'b1;
        cpu_dout_o  = hit_data_i;
      end
      ST_RMISS: begin
        // allocate the fetched word.
        if (ram_ready_i) begin
          cpu_ready_o = 1'b1;
          fill_we_o   = 1'b1;
        end
      end
      ST_WRITE: begin
        if (ram_ready_i) begin
          cpu_ready_o = 1'b1;
          // partial miss leaves the cache alone.
          fill_we_o   = req_hit_q || req_full;
          if (req_hit_q) begin
            fill_data_o = merge_bytes(hit_data_i, req_wdata_q, req_wmask_q);
          end else begin
            fill_data_o = req_wdata_q;
          end
        end
      end
      default: begin
        cpu_ready_o = 1'b0;
      end
    endcase
  end

  a_no_ready_idle: assert property (
    @(posedge clk) disable iff (!resetn) in_idle |-> !cpu_ready_o
  );

  // an accepted read miss requests memory with a zero mask in the next cycle.
  a_rmiss_read_mask: assert property (
    @(posedge clk) disable iff (!resetn)
    (accept && !hit_i && cpu_wmask_i == 4'b0000)
      |=> (ram_valid_o && ram_wmask_o == 4'b0000)
  );

  // a read hit is answered in the very next cycle.
  a_rhit_latency: assert property (
    @(posedge clk) disable iff (!resetn)
    (accept && hit_i && cpu_wmask_i == 4'b0000) |=> (cpu_ready_o && !ram_valid_o)
  );

endmodule

`default_nettype wire

//--- design/dcache_defines.svh
// dcache geometry.
// Set count of the two-way write-through data cache and the index and tag
// widths that follow from it for a 32-bit byte address with word lines.

`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// number of sets per way, a power of two.
`define DC_SETS 64

// index bits select a set.
`define DC_IDX_W $clog2(`DC_SETS)

// the tag is what is left above the index and the two byte-offset bits.
`define DC_TAG_W (32 - `DC_IDX_W - 2)

`endif

//--- design/dcache_pkg.sv
// dcache types.
// Address word seen raw or split into tag, index and byte offset, and the
// tag and data pair that each way stores per set.

`default_nettype none

`include "dcache_defines.svh"

package dcache_pkg;

  typedef logic [`DC_TAG_W-1:0] dc_tag_t;
  typedef logic [`DC_IDX_W-1:0] dc_idx_t;

  // field view of a byte address, msb first.
  typedef struct packed {
    dc_tag_t    tag;
    dc_idx_t    idx;
    logic [1:0] off;
  } dc_addr_s;

  // one address word, decoded either way.
  typedef union packed {
    logic [31:0] raw;
    dc_addr_s    f;
  } dc_addr_u;

  // stored line of one way; the valid bit is kept apart.
  typedef struct packed {
    dc_tag_t     tag;
    logic [31:0] data;
  } dc_line_t;

endpackage

`default_nettype wire

//--- design/dcache_top.sv
// Data cache top level.
// Joins the controller and the two-way store between the CPU load/store
// port and the word-wide memory port.

`timescale 1ns/1ps
`default_nettype none

module dcache_top (
  input  logic        clk,
  input  logic        resetn,
  input  logic [31:0] cpu_addr_i,
  input  logic [3:0]  cpu_wmask_i,
  input  logic [31:0] cpu_din_i,
  input  logic        cpu_valid_i,
  output logic [31:0] cpu_dout_o,
  output logic        cpu_ready_o,
  output logic [31:0] ram_addr_o,
  output logic [3:0]  ram_wmask_o,
  output logic [31:0] ram_wdata_o,
  input  logic [31:0] ram_rdata_i,
  output logic        ram_valid_o,
  input  logic        ram_ready_i
);

  import dcache_pkg::*;

  dc_addr_u    lookup_addr;
  logic        lookup_use;
  logic        fill_we;
  logic [31:0] fill_data;
  logic        hit;
  logic [31:0] hit_data;

  dcache_ctrl u_ctrl (
    .clk           (clk),
    .resetn        (resetn),
    .cpu_addr_i    (cpu_addr_i),
    .cpu_wmask_i   (cpu_wmask_i),
    .cpu_din_i     (cpu_din_i),
    .cpu_valid_i   (cpu_valid_i),
    .cpu_dout_o    (cpu_dout_o),
    .cpu_ready_o   (cpu_ready_o),
    .ram_addr_o    (ram_addr_o),
    .ram_wmask_o   (ram_wmask_o),
    .ram_wdata_o   (ram_wdata_o),
    .ram_rdata_i   (ram_rdata_i),
    .ram_valid_o   (ram_valid_o),
    .ram_ready_i   (ram_ready_i),
    .lookup_addr_o (lookup_addr),
    .lookup_use_o  (lookup_use),
    .fill_we_o     (fill_we),
    .fill_data_o   (fill_data),
    .hit_i         (hit),
    .hit_data_i    (hit_data)
  );

  assoc_cache u_store (
    .clk           (clk),
    .resetn        (resetn),
    .lookup_addr_i (lookup_addr),
    .lookup_use_i  (lookup_use),
    .fill_we_i     (fill_we),
    .fill_data_i   (fill_data),
    .hit_o         (hit),
    .hit_data_o    (hit_data)
  );

endmodule

`default_nettype wire

//--- design/replace_lru.sv
// LRU state for the two-way cache.
// One bit per set names the way to evict next; touching a way points the
// bit at the other one.

`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module replace_lru (
  input  logic                clk,
  input  logic                resetn,
  input  dcache_pkg::dc_idx_t idx_i,
  input  logic                touch_i,
  input  logic                touch_way_i,
  output logic                victim_o
);

  // bit set means way 1 is the next victim.
  logic [`DC_SETS-1:0] victim_q;

  assign victim_o = victim_q[idx_i];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      victim_q <= '0;
    end else if (touch_i) begin
      // the way just used becomes most recent.
      victim_q[idx_i] <= ~touch_way_i;
    end
  end

endmodule

`default_nettype wire

//--- design/way_store.sv
// One way of the data cache.
// Per set a valid bit, a tag and one data word. Lookup is combinational
// at the read index; a fill writes the line at that same index.

`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module way_store (
  input  logic                clk,
  input  logic                resetn,
  input  dcache_pkg::dc_idx_t rd_idx_i,
  input  dcache_pkg::dc_tag_t rd_tag_i,
  input  logic                we_i,
  input  logic [31:0]         wdata_i,
  output logic                match_o,
  output logic [31:0]         data_o
);

  import dcache_pkg::*;

  logic [`DC_SETS-1:0] valid_q;
  dc_line_t            lines_q [`DC_SETS];
  dc_line_t            rd_line;

  // asynchronous read of the addressed line.
  assign rd_line = lines_q[rd_idx_i];

  assign match_o = valid_q[rd_idx_i] && (rd_line.tag == rd_tag_i);
  assign data_o  = rd_line.data;

  // valid bits are the only control state here.
  always_ff @(posedge clk) begin
    if (!resetn) begin
      valid_q <= '0;
    end else if (we_i) begin
      valid_q[rd_idx_i] <= 1'b1;
    end
  end

  // tag and data array.
  always_ff @(posedge clk) begin
    if (we_i) begin
      lines_q[rd_idx_i].tag  <= rd_tag_i;
      lines_q[rd_idx_i].data <= wdata_i;
    end
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+design
design/dcache_pkg.sv
design/way_store.sv
design/replace_lru.sv
design/assoc_cache.sv
design/dcache_ctrl.sv
design/dcache_top.sv
test/tb_dcache.sv

//--- run.sh
#!/bin/sh
# Build the data cache testbench with Verilator and run it.
# The exit status of the simulation is the result.

cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f list.f --top-module tb_dcache -o tb_dcache &&
./obj_dir/tb_dcache || exit 1

//--- test/tb_dcache.sv
// Testbench for the write-through data cache.
// Drives random loads and stores from a fixed LFSR seed over a small address
// pool, answers the memory port from a word model and predicts hits with a
// two-way LRU tag model.

`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module tb_dcache;

  localparam int          CLK_PERIOD = 40;
  localparam int          DRIVE_DLY  = 2;
  localparam int          RESP_LIMIT = 16;
  localparam int          NUM_REQ    = 400;
  localparam logic [31:0] SEED       = 32'h5c17_093a;

  logic        clk;
  logic        resetn;
  logic [31:0] cpu_addr_i;
  logic [3:0]  cpu_wmask_i;
  logic [31:0] cpu_din_i;
  logic        cpu_valid_i;
  logic [31:0] cpu_dout_o;
  logic        cpu_ready_o;
  logic [31:0] ram_addr_o;
  logic [3:0]  ram_wmask_o;
  logic [31:0] ram_wdata_o;
  logic [31:0] ram_rdata_i;
  logic        ram_valid_o;
  logic        ram_ready_i;

  logic [31:0] lfsr_q;
  logic [31:0] mem_q [logic [31:0]];
  // tag model where victim_m names the way to evict next.
  logic        valid_m [`DC_SETS][2];
  logic [31:0] tag_m [`DC_SETS][2];
  logic        victim_m [`DC_SETS];

  dcache_top uut (
    .clk         (clk),
    .resetn      (resetn),
    .cpu_addr_i  (cpu_addr_i),
    .cpu_wmask_i (cpu_wmask_i),
    .cpu_din_i   (cpu_din_i),
    .cpu_valid_i (cpu_valid_i),
    .cpu_dout_o  (cpu_dout_o),
    .cpu_ready_o (cpu_ready_o),
    .ram_addr_o  (ram_addr_o),
    .ram_wmask_o (ram_wmask_o),
    .ram_wdata_o (ram_wdata_o),
    .ram_rdata_i (ram_rdata_i),
    .ram_valid_o (ram_valid_o),
    .ram_ready_i (ram_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // fibonacci lfsr with taps 32 22 2 1 and one step per bit taken.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  // four sets with three tags each so that sets overflow and evict.
  function automatic logic [31:0] pick_addr();
    logic [31:0] idx;
    logic [31:0] tag;
    case (rand_bits(2))
      32'd0:   idx = 32'd3;
      32'd1:   idx = 32'd17;
      32'd2:   idx = 32'd42;
      default: idx = 32'd63;
    endcase
    case (rand_bits(2))
      32'd0:   tag = 32'h0001a2;
      32'd1:   tag = 32'h03c0c1;
      default: tag = 32'h800077;
    endcase
    return (tag << (`DC_IDX_W + 2)) | (idx << 2);
  endfunction

  function automatic logic [3:0] pick_mask();
    logic [3:0] m;
    case (rand_bits(2))
      32'd2: m = 4'b1111;
      32'd3: begin
        m = 4'(rand_bits(4));
        if (m == 4'b0000 || m == 4'b1111) begin
          m = 4'b0110;
        end
      end
      default: m = 4'b0000;
    endcase
    return m;
  endfunction

  // untouched memory words differ with every address bit.
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    if (mem_q.exists(addr)) begin
      return mem_q[addr];
    end
    return {addr[15:0], addr[31:16]} ^ 32'hc3a5_5a3c;
  endfunction

  task automatic store_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] mask);
    logic [31:0] w;
    w = mem_word(addr);
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        w[8*b +: 8] = data[8*b +: 8];
      end
    end
    mem_q[addr] = w;
  endtask

  function automatic logic predict_hit(input logic [31:0] addr, output logic way);
    int          set;
    logic [31:0] tag;
    logic        m0;
    logic        m1;
    set = int'((addr >> 2) & (`DC_SETS - 1));
    tag = addr >> (`DC_IDX_W + 2);
    m0  = valid_m[set][0] && (tag_m[set][0] == tag);
    m1  = valid_m[set][1] && (tag_m[set][1] == tag);
    way = m1;
    return m0 || m1;
  endfunction

  // reads and full writes allocate on a miss but partial write misses do not.
  task automatic track_access(input logic [31:0] addr, input logic [3:0] mask);
    int          set;
    logic        hit;
    logic        way;
    set = int'((addr >> 2) & (`DC_SETS - 1));
    hit = predict_hit(addr, way);
    if (!hit && (mask == 4'b0000 || mask == 4'b1111)) begin
      way                = victim_m[set];
      valid_m[set][way]  = 1'b1;
      tag_m[set][way]    = addr >> (`DC_IDX_W + 2);
      hit                = 1'b1;
    end
    if (hit) begin
      victim_m[set] = ~way;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (act_v !== exp_v) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp_v, act_v);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    $display("STATUS: FAIL");
    $fatal(1, "wait limit exceeded");
  endtask

  // one request from drive to completion with a random memory delay.
  task automatic do_request(input logic [31:0] addr, input logic [3:0] mask,
                            input logic [31:0] data);
    logic        exp_hit;
    logic        way;
    logic [31:0] old_word;
    int          cycles;
    int          delay;
    exp_hit  = predict_hit(addr, way);
    old_word = mem_word(addr);
    @(posedge clk);
    #DRIVE_DLY;
    cpu_addr_i  = addr;
    cpu_wmask_i = mask;
    cpu_din_i   = data;
    cpu_valid_i = 1'b1;
    @(negedge clk);
    check_value("cpu_ready_o", 32'd0, 32'(cpu_ready_o));
    check_value("ram_valid_o", 32'd0, 32'(ram_valid_o));
    cycles = 1;
    @(negedge clk);
    while (!cpu_ready_o && !ram_valid_o) begin
      if (cycles >= RESP_LIMIT) begin
        stop_on_timeout("cpu_ready_o or ram_valid_o");
      end
      @(negedge clk);
      cycles++;
    end
    check_value("response latency", 32'd1, cycles);
    if (mask == 4'b0000 && exp_hit) begin
      check_value("cpu_ready_o", 32'd1, 32'(cpu_ready_o));
      check_value("ram_valid_o", 32'd0, 32'(ram_valid_o));
      check_value("cpu_dout_o", old_word, cpu_dout_o);
      @(posedge clk);
      #DRIVE_DLY;
      cpu_valid_i = 1'b0;
    end else begin
      check_value("ram_valid_o", 32'd1, 32'(ram_valid_o));
      check_value("cpu_ready_o", 32'd0, 32'(cpu_ready_o));
      delay = rand_bits(2);
      for (int i = 0; i <= delay; i++) begin
        @(posedge clk);
        #DRIVE_DLY;
        if (i == delay) begin
          ram_ready_i = 1'b1;
          ram_rdata_i = old_word;
        end
        @(negedge clk);
        check_value("ram_valid_o", 32'd1, 32'(ram_valid_o));
        check_value("ram_addr_o", addr, ram_addr_o);
        check_value("ram_wmask_o", 32'(mask), 32'(ram_wmask_o));
        if (mask != 4'b0000) begin
          check_value("ram_wdata_o", data, ram_wdata_o);
        end
        check_value("cpu_ready_o", 32'(i == delay), 32'(cpu_ready_o));
      end
      if (mask == 4'b0000) begin
        check_value("cpu_dout_o", old_word, cpu_dout_o);
      end
      @(posedge clk);
      #DRIVE_DLY;
      ram_ready_i = 1'b0;
      ram_rdata_i = ~old_word;
      cpu_valid_i = 1'b0;
      if (mask != 4'b0000) begin
        store_word(addr, data, mask);
      end
    end
    track_access(addr, mask);
  endtask

  initial begin
    int          n;
    logic [31:0] addr;
    logic [31:0] addr_b;
    logic [3:0]  mask;
    lfsr_q      = SEED;
    resetn      = 1'b0;
    cpu_addr_i  = '0;
    cpu_wmask_i = '0;
    cpu_din_i   = '0;
    cpu_valid_i = 1'b0;
    ram_rdata_i = '0;
    ram_ready_i = 1'b0;
    for (int s = 0; s < `DC_SETS; s++) begin
      valid_m[s][0] = 1'b0;
      valid_m[s][1] = 1'b0;
      tag_m[s][0]   = '0;
      tag_m[s][1]   = '0;
      victim_m[s]   = 1'b0;
    end
    repeat (2) @(posedge clk);
    #DRIVE_DLY;
    resetn = 1'b1;
    // nothing moves before the first request.
    repeat (3) begin
      @(negedge clk);
      check_value("cpu_ready_o", 32'd0, 32'(cpu_ready_o));
      check_value("ram_valid_o", 32'd0, 32'(ram_valid_o));
    end
    // a write hit merge and then a partial write miss that must not allocate.
    addr   = (32'h001234 << (`DC_IDX_W + 2)) | (32'd5 << 2);
    addr_b = (32'h00abcd << (`DC_IDX_W + 2)) | (32'd9 << 2);
    do_request(addr, 4'b0000, 32'd0);
    do_request(addr, 4'b0110, 32'hdead_beef);
    do_request(addr, 4'b0000, 32'd0);
    do_request(addr_b, 4'b0001, 32'h0000_0055);
    do_request(addr_b, 4'b0000, 32'd0);
    n = 5;
    while (n < NUM_REQ) begin
      addr = pick_addr();
      mask = pick_mask();
      do_request(addr, mask, rand_bits(32));
      n++;
      // sometimes read back what was just written.
      if (mask != 4'b0000 && rand_bits(1) == 32'd1) begin
        do_request(addr, 4'b0000, 32'd0);
        n++;
      end
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire
